//--- Makefile
# Verilator build and run for the memory bank testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mem_bank
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and fail unless the run passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- tb.f
verilog/mem_pkg.sv
verilog/sram_cut.sv
verilog/bank_req_check.sv
verilog/sram.sv
verilog/bank_rsp_gen.sv
verilog/mem_bank_top.sv
test/tb_mem_bank.sv

//--- test/mem_bank_input.txt
# columns: test op addr wdata be exp_rdata exp_err
# test in decimal, the rest in hex; op 0 read, 1 write, 2 idle cycle
1 1 03ff a0a00001 f 00000000 0
1 1 0400 b1b10002 f 00000000 0
1 1 0812 c2c20003 f 00000000 0
1 1 0c34 d3d30004 f 00000000 0
1 1 13ff e4e40005 f 00000000 0
1 0 03ff 00000000 0 a0a00001 0
1 0 0400 00000000 0 b1b10002 0
1 0 0812 00000000 0 c2c20003 0
1 0 0c34 00000000 0 d3d30004 0
1 0 13ff 00000000 0 e4e40005 0
1 2 0000 00000000 0 00000000 0
2 1 0100 11223344 f 00000000 0
2 1 0100 aabbccdd 5 00000000 0
2 0 0100 00000000 0 11bb33dd 0
2 1 0100 aabbccdd 2 00000000 0
2 0 0100 00000000 0 11bbccdd 0
2 1 0100 00000000 0 00000000 0
2 0 0100 00000000 0 11bbccdd 0
2 2 0000 00000000 0 00000000 0
3 0 03ff 00000000 0 a0a00001 0
3 0 13ff 00000000 0 e4e40005 0
3 0 0400 00000000 0 b1b10002 0
3 0 03ff 00000000 0 a0a00001 0
3 0 0812 00000000 0 c2c20003 0
3 1 0812 12345678 f 00000000 0
3 0 0812 00000000 0 12345678 0
3 0 0c34 00000000 0 d3d30004 0
3 2 0000 00000000 0 00000000 0
4 1 0000 0f0f0f0f f 00000000 0
4 1 1000 76543210 f 00000000 0
4 0 1000 00000000 0 76543210 0
4 0 1400 00000000 0 00000000 1
4 1 1400 deadbeef f 00000000 1
4 1 1fff cafef00d f 00000000 1
4 0 1fff 00000000 0 00000000 1
4 0 0000 00000000 0 0f0f0f0f 0
4 0 1000 00000000 0 76543210 0
4 0 03ff 00000000 0 a0a00001 0
4 0 13ff 00000000 0 e4e40005 0
4 2 0000 00000000 0 00000000 0
5 2 0000 00000000 0 00000000 0
5 2 0000 00000000 0 00000000 0
5 1 0200 01020304 f 00000000 0
5 0 0200 00000000 0 01020304 0
5 1 0600 55aa55aa f 00000000 0
5 0 0600 00000000 0 55aa55aa 0
5 0 0200 00000000 0 01020304 0
5 2 0000 00000000 0 00000000 0
5 2 0000 00000000 0 00000000 0

//--- test/tb_mem_bank.sv
// Memory bank testbench
`timescale 1ns/100ps
`default_nettype none

module tb_mem_bank;

  localparam int MAX_LINES = 256;
  // op codes used in the data file
  localparam int OP_CODE_WRITE = 1;
  localparam int OP_CODE_IDLE  = 2;

  logic              CLK;
  logic              RSTN;
  logic              req;
  mem_pkg::mem_req_t req_bus;
  logic              rsp_valid;
  mem_pkg::mem_rsp_t rsp;

  // one entry per request line of the data file
  int unsigned                     f_test  [MAX_LINES];
  int unsigned                     f_op    [MAX_LINES];
  logic [mem_pkg::ADDR_WIDTH-1:0]  f_addr  [MAX_LINES];
  logic [31:0]                     f_wdata [MAX_LINES];
  logic [3:0]                      f_be    [MAX_LINES];
  logic [31:0]                     f_rdata [MAX_LINES];
  logic                            f_err   [MAX_LINES];

  int n_lines;
  int file_lines;
  int checks;
  int errors;
  int test_checks;
  int test_errs;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  bit loaded = 1'b0;

  mem_bank_top dut (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .req_i       (req),
    .req_bus_i   (req_bus),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // run limit from reset length plus two cycles per file line
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (loaded && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    int unsigned t;
    int unsigned op;
    logic [mem_pkg::ADDR_WIDTH-1:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] rdata;
    logic        err;
    fd = $fopen("test/mem_bank_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file test/mem_bank_input.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        file_lines++;
        // comment lines start with a hash
        if (line.len() > 0 && line[0] != "#" && n_lines < MAX_LINES) begin
          n = $sscanf(line, "%d %h %h %h %h %h %h", t, op, addr, wdata, be, rdata, err);
          if (n == 7) begin
            f_test[n_lines]  = t;
            f_op[n_lines]    = op;
            f_addr[n_lines]  = addr;
            f_wdata[n_lines] = wdata;
            f_be[n_lines]    = be;
            f_rdata[n_lines] = rdata;
            f_err[n_lines]   = err;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_value(input int test_no, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("ERR test %0d %s: got %08h expected %08h", test_no, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic drive_line(input int k);
    if (f_op[k] == OP_CODE_IDLE) begin
      req     = 1'b0;
      req_bus = '0;
    end else begin
      req           = 1'b1;
      req_bus.op    = (f_op[k] == OP_CODE_WRITE) ? mem_pkg::OP_WRITE : mem_pkg::OP_READ;
      req_bus.addr  = f_addr[k];
      req_bus.wdata = f_wdata[k];
      req_bus.be    = f_be[k];
    end
  endtask

  // response of line k, sampled one cycle after it was driven
  task automatic check_response(input int k);
    int t;
    t = int'(f_test[k]);
    if (f_op[k] == OP_CODE_IDLE) begin
      if (rsp_valid !== 1'b0) begin
        $display("test %0d: a response strobe appeared after an idle cycle", t);
        errors++;
        test_errs++;
      end
    end else if (rsp_valid !== 1'b1) begin
      $display("test %0d: no response one cycle after the request at %04h", t, f_addr[k]);
      errors++;
      test_errs++;
    end else begin
      compare_value(t, "rsp_o.rdata", rsp.rdata, f_rdata[k]);
      compare_value(t, "rsp_o.err", {31'b0, rsp.err}, {31'b0, f_err[k]});
    end
    if (k == n_lines - 1 || f_test[k + 1] != f_test[k]) begin
      $display("test %0d finished: %0d checks, %0d errors", t, test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
    end
  endtask

  initial begin
    RSTN        = 1'b0;
    req         = 1'b0;
    req_bus     = '0;
    n_lines     = 0;
    file_lines  = 0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errs   = 0;
    load_stimulus();
    cycle_limit = 16 + 2 * file_lines + 50;
    loaded      = 1'b1;

    // read strobes of address zero while in reset must not give a response
    req = 1'b1;
    repeat (16) begin
      @(negedge CLK);
      if (rsp_valid !== 1'b0) begin
        $display("a response strobe appeared during reset");
        errors++;
      end
    end
    req  = 1'b0;
    RSTN = 1'b1;

    // one line per cycle, the previous line is checked with the next request on the bus
    for (int i = 0; i <= n_lines; i++) begin
      @(negedge CLK);
      if (i < n_lines) begin
        drive_line(i);
      end else begin
        req     = 1'b0;
        req_bus = '0;
      end
      if (i > 0) begin
        #2;
        check_response(i - 1);
      end
    end

    $display("done: %0d requests, %0d checks, %0d errors", n_lines, checks, errors);
    if (errors == 0 && n_lines > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bank_req_check.sv
// Bank request check and cut select
`timescale 1ns/100ps
`default_nettype none

module bank_req_check (
  input  logic                                 req_i,
  input  mem_pkg::mem_req_t                    req_bus_i,
  output logic                                 cut_en_o,
  output logic [mem_pkg::CUT_SEL_WIDTH-1:0]    cut_sel_o,
  output mem_pkg::cut_req_t                    cut_req_o,
  output logic                                 acc_o,
  output logic                                 is_read_o,
  output logic                                 range_err_o
);

  logic in_range;

  // only the first N_WORDS addresses are backed by a cut
  assign in_range = int'(req_bus_i.addr) < mem_pkg::N_WORDS;

  // every strobe is an access, accepted or refused
  assign acc_o       = req_i;
  assign is_read_o   = (req_bus_i.op == mem_pkg::OP_READ);
  assign range_err_o = ~in_range;

  // a refused request must not touch any cut
  assign cut_en_o = req_i & in_range;

  // upper bits pick the cut, lower bits address within it
  assign cut_sel_o =
    req_bus_i.addr[mem_pkg::ADDR_WIDTH-1 -: mem_pkg::CUT_SEL_WIDTH];

  always_comb begin
    cut_req_o.we    = (req_bus_i.op == mem_pkg::OP_WRITE);
    cut_req_o.addr  = req_bus_i.addr[mem_pkg::CUT_ADDR_WIDTH-1:0];
    cut_req_o.wdata = req_bus_i.wdata;
    // one byte enable spreads over eight bit enables
    for (int b = 0; b < mem_pkg::STRB_WIDTH; b++) begin
      cut_req_o.bw[b*8 +: 8] = {8{req_bus_i.be[b]}};
    end
  end

  // the request bus must be fully driven whenever it is strobed
  always_comb begin
    if (req_i) begin
      assert (!$isunknown(req_bus_i))
        else $error("request bus has unknown bits while req_i is high");
    end
  end

endmodule

`default_nettype wire

//--- verilog/bank_rsp_gen.sv
// Bank response generation
`timescale 1ns/100ps
`default_nettype none

module bank_rsp_gen (
  input  wire                              CLK,
  input  wire                              RSTN,
  input  logic                             acc_i,
  input  logic                             is_read_i,
  input  logic                             range_err_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]   rdata_i,
  output logic                             rsp_valid_o,
  output mem_pkg::mem_rsp_t                rsp_o
);

  logic acc_q;
  logic rd_q;
  logic err_q;

  // flags follow the access strobe by one cycle, in step with the cut read
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      acc_q <= 1'b0;
      rd_q  <= 1'b0;
      err_q <= 1'b0;
    end else begin
      acc_q <= acc_i;
      rd_q  <= acc_i & is_read_i;
      err_q <= acc_i & range_err_i;
    end
  end

  assign rsp_valid_o = acc_q;

  // writes and refused accesses return zero data
  always_comb begin
    rsp_o.rdata = (rd_q & ~err_q) ? rdata_i : '0;
    rsp_o.err   = err_q;
  end

  // no response without an access one cycle earlier
  a_no_spurious_rsp: assert property (
    @(posedge CLK) disable iff (!RSTN)
    !acc_i |=> !rsp_valid_o
  ) else $error("response without a preceding access");

endmodule

`default_nettype wire

//--- verilog/mem_bank_top.sv
// Data memory bank top level
`timescale 1ns/100ps
`default_nettype none

module mem_bank_top (
  input  wire                CLK,
  input  wire                RSTN,
  input  logic               req_i,
  input  mem_pkg::mem_req_t  req_bus_i,
  output logic               rsp_valid_o,
  output mem_pkg::mem_rsp_t  rsp_o
);

  // input side to cut array
  logic                               cut_en;
  logic [mem_pkg::CUT_SEL_WIDTH-1:0]  cut_sel;
  mem_pkg::cut_req_t                  cut_req;

  // input side to response side
  logic acc;
  logic is_read;
  logic range_err;

  logic [mem_pkg::DATA_WIDTH-1:0] rdata;

  bank_req_check i_req_check (
    .req_i       (req_i),
    .req_bus_i   (req_bus_i),
    .cut_en_o    (cut_en),
    .cut_sel_o   (cut_sel),
    .cut_req_o   (cut_req),
    .acc_o       (acc),
    .is_read_o   (is_read),
    .range_err_o (range_err)
  );

  sram i_sram (
    .CLK       (CLK),
    .RSTN      (RSTN),
    .cut_en_i  (cut_en),
    .cut_sel_i (cut_sel),
    .cut_req_i (cut_req),
    .rdata_o   (rdata)
  );

  bank_rsp_gen i_rsp_gen (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .acc_i       (acc),
    .is_read_i   (is_read),
    .range_err_i (range_err),
    .rdata_i     (rdata),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
// Data memory bank definitions
`default_nettype none

package mem_pkg;

  // bank geometry
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int unsigned CUT_WORDS      = 1024;
  localparam int unsigned NB_CUTS        = 5;
  localparam int unsigned N_WORDS        = CUT_WORDS * NB_CUTS;
  // 13 bits, so 5120..8191 are addressable but out of range
  localparam int unsigned ADDR_WIDTH     = $clog2(N_WORDS);
  localparam int unsigned CUT_ADDR_WIDTH = $clog2(CUT_WORDS);
  localparam int unsigned CUT_SEL_WIDTH  = ADDR_WIDTH - CUT_ADDR_WIDTH;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // request as seen at the bank boundary
  typedef struct packed {
    mem_op_e                 op;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [STRB_WIDTH-1:0]   be;
  } mem_req_t;

  // request as presented to a single cut, bw is one enable per data bit
  typedef struct packed {
    logic                      we;
    logic [CUT_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     wdata;
    logic [DATA_WIDTH-1:0]     bw;
  } cut_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/sram.sv
// Cut array with registered read select
`timescale 1ns/100ps
`default_nettype none

module sram (
  input  wire                                 CLK,
  input  wire                                 RSTN,
  input  logic                                cut_en_i,
  input  logic [mem_pkg::CUT_SEL_WIDTH-1:0]   cut_sel_i,
  input  mem_pkg::cut_req_t                   cut_req_i,
  output logic [mem_pkg::DATA_WIDTH-1:0]      rdata_o
);

  logic [mem_pkg::NB_CUTS-1:0]                          cut_ce;
  logic [mem_pkg::NB_CUTS-1:0][mem_pkg::DATA_WIDTH-1:0] cut_q;

  // cut index of the last enabled access, steers the output mux
  logic [mem_pkg::CUT_SEL_WIDTH-1:0] sel_q;

  // one-hot chip enables from the cut index
  always_comb begin
    cut_ce = '0;
    for (int c = 0; c < mem_pkg::NB_CUTS; c++) begin
      if (cut_sel_i == mem_pkg::CUT_SEL_WIDTH'(c)) begin
        cut_ce[c] = cut_en_i;
      end
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      sel_q <= '0;
    end else if (cut_en_i) begin
      sel_q <= cut_sel_i;
    end
  end

  for (genvar i = 0; i < mem_pkg::NB_CUTS; i++) begin : gen_cut
    sram_cut i_cut (
      .CLK   (CLK),
      .ce_i  (cut_ce[i]),
      .req_i (cut_req_i),
      .q_o   (cut_q[i])
    );
  end

  // read mux, cut outputs hold so the word stays stable until the next access
  always_comb begin
    rdata_o = '0;
    for (int c = 0; c < mem_pkg::NB_CUTS; c++) begin
      if (sel_q == mem_pkg::CUT_SEL_WIDTH'(c)) begin
        rdata_o = cut_q[c];
      end
    end
  end

  // never more than one cut active in a cycle
  a_ce_onehot: assert property (
    @(posedge CLK) disable iff (!RSTN)
    $onehot0(cut_ce)
  ) else $error("more than one cut enable active");

  // the select must always point at an existing cut
  a_sel_range: assert property (
    @(posedge CLK) disable iff (!RSTN)
    sel_q <= mem_pkg::CUT_SEL_WIDTH'(mem_pkg::NB_CUTS - 1)
  ) else $error("read select beyond last cut");

endmodule

`default_nettype wire

//--- verilog/sram_cut.sv
// Behavioral SRAM cut
`timescale 1ns/100ps
`default_nettype none

module sram_cut (
  input  wire                              CLK,
  input  logic                             ce_i,
  input  mem_pkg::cut_req_t                req_i,
  output logic [mem_pkg::DATA_WIDTH-1:0]   q_o
);

  // storage array, contents undefined after power up
  logic [mem_pkg::DATA_WIDTH-1:0] mem [mem_pkg::CUT_WORDS];

  logic [mem_pkg::DATA_WIDTH-1:0] cur_word;
  logic [mem_pkg::DATA_WIDTH-1:0] merged_word;

  assign cur_word = mem[req_i.addr];

  // bit-masked merge of new data into the stored word
  assign merged_word = (cur_word & ~req_i.bw) | (req_i.wdata & req_i.bw);

  // single port: one access per enabled cycle
  // a write leaves q_o untouched, as a real cut would
  always_ff @(posedge CLK) begin
    if (ce_i) begin
      if (req_i.we) begin
        mem[req_i.addr] <= merged_word;
      end else begin
        q_o <= cur_word;
      end
    end
  end

endmodule

`default_nettype wire
